//--- all.f
+incdir+hdl
hdl/classifier_pkg.sv
hdl/decode_if.sv
hdl/rv32_decode.sv
hdl/rvc_decode.sv
hdl/decode_merge.sv
hdl/instr_classifier.sv
bench/classifier_props.sv
bench/classifier_tb.sv

//--- bench/classifier_props.sv
/*
 * Classifier output properties.
 * Valid timing around reset and register usage rules on the
 * registered classifier outputs, bound into the top level.
 */
`timescale 1ns/1ps
`default_nettype none

module classifier_props import classifier_pkg::*; (
    input logic   s_clk_i,
    input logic   rst_i,
    input logic   valid_i,
    input logic   res_valid_i,
    input itype_e res_itype_i,
    input logic   rs1_used_i,
    input logic   rs2_used_i,
    input logic   rd_used_i
);

    valid_follows: assert property (@(posedge s_clk_i) disable iff (rst_i)
        !$past(rst_i) |-> res_valid_i == $past(valid_i))
        else $error("valid_o does not follow valid_i of the previous cycle");

    // Covers the reset cycles and the first cycle after release.
    valid_low_after_reset: assert property (@(posedge s_clk_i)
        $past(rst_i) |-> !res_valid_i)
        else $error("valid_o is high right after reset");

    rs2_needs_rs1: assert property (@(posedge s_clk_i) disable iff (rst_i)
        rs2_used_i |-> rs1_used_i)
        else $error("rs2_used_o is set without rs1_used_o");

    no_rd_on_branch_store: assert property (@(posedge s_clk_i) disable iff (rst_i)
        (res_itype_i == BRANCH || res_itype_i == STORE) |-> !rd_used_i)
        else $error("branch or store result writes a destination register");

endmodule

bind instr_classifier classifier_props props0 (
    .s_clk_i     (s_clk_i),
    .rst_i       (rst_i),
    .valid_i     (valid_i),
    .res_valid_i (valid_o),
    .res_itype_i (itype_o),
    .rs1_used_i  (rs1_used_o),
    .rs2_used_i  (rs2_used_o),
    .rd_used_i   (rd_used_o)
);

`default_nettype wire

//--- bench/classifier_tb.sv
/*
 * Instruction classifier testbench.
 * Applies a table of 32-bit and compressed encodings with bubbles
 * and checks each registered result one cycle after its strobe.
 */
`timescale 1ns/1ps
`default_nettype none

`include "classifier_settings.svh"

module classifier_tb import classifier_pkg::*; ();

    typedef struct {
        logic [`CLS_ILEN-1:0] instr;
        logic                 bubble;     // Idle cycle before this entry.
        itype_e               itype;
        logic                 comp;
        logic                 known;
        logic [`CLS_RAW-1:0]  rs1;
        logic                 rs1_used;
        logic [`CLS_RAW-1:0]  rs2;
        logic                 rs2_used;
        logic [`CLS_RAW-1:0]  rd;
        logic                 rd_used;
    } entry_t;

    logic                 s_clk_i;
    logic                 rst_i;
    logic                 valid_i;
    logic [`CLS_ILEN-1:0] instr_i;
    logic                 valid_o;
    logic                 compressed_o;
    logic                 known_o;
    itype_e               itype_o;
    logic [`CLS_RAW-1:0]  rs1_o;
    logic [`CLS_RAW-1:0]  rs2_o;
    logic [`CLS_RAW-1:0]  rd_o;
    logic                 rs1_used_o;
    logic                 rs2_used_o;
    logic                 rd_used_o;

    entry_t tbl[$];
    int     checks;
    int     value_errors;
    int     timeout_errors;
    int     seed = 6650;

    instr_classifier dut0 (
        .s_clk_i      (s_clk_i),
        .rst_i        (rst_i),
        .valid_i      (valid_i),
        .instr_i      (instr_i),
        .valid_o      (valid_o),
        .compressed_o (compressed_o),
        .known_o      (known_o),
        .itype_o      (itype_o),
        .rs1_o        (rs1_o),
        .rs2_o        (rs2_o),
        .rd_o         (rd_o),
        .rs1_used_o   (rs1_used_o),
        .rs2_used_o   (rs2_used_o),
        .rd_used_o    (rd_used_o)
    );

    initial s_clk_i = 1'b0;
    always #50 s_clk_i = ~s_clk_i;

    initial begin
        rst_i   = 1'b1;
        valid_i = 1'b0;
        instr_i = '0;
        repeat (16) @(posedge s_clk_i);
        rst_i <= 1'b0;
    end

    function automatic void add_entry(input logic [31:0] instr, input logic bubble,
                                      input itype_e itype, input logic comp,
                                      input logic known, input logic [4:0] rs1,
                                      input logic rs1_used, input logic [4:0] rs2,
                                      input logic rs2_used, input logic [4:0] rd,
                                      input logic rd_used);
        entry_t e;
        e = '{instr, bubble, itype, comp, known, rs1, rs1_used, rs2, rs2_used, rd, rd_used};
        tbl.push_back(e);
    endfunction

    function automatic void load_table();
        // Word, bubble, class, compressed, known, rs1, used, rs2, used, rd, used.
        add_entry(32'h123452B7, 0, BASE,   0, 1,  0, 0,  0, 0,  5, 1);  // Lui x5.
        add_entry(32'h100000EF, 0, JAL,    0, 1,  0, 0,  0, 0,  1, 1);
        add_entry(32'h000300E7, 0, JALR,   0, 1,  6, 1,  0, 0,  1, 1);
        add_entry(32'h00418463, 0, BRANCH, 0, 1,  3, 1,  4, 1,  0, 0);  // Beq x3, x4.
        add_entry(32'h00412383, 0, LOAD,   0, 1,  2, 1,  0, 0,  7, 1);  // Lw x7, 4(x2).
        add_entry(32'h00952423, 0, STORE,  0, 1, 10, 1,  9, 1,  0, 0);  // Sw x9, 8(x10).
        add_entry(32'hFFF60593, 0, BASE,   0, 1, 12, 1,  0, 0, 11, 1);  // Addi.
        add_entry(32'h00F706B3, 0, BASE,   0, 1, 14, 1, 15, 1, 13, 1);  // Add.
        add_entry(32'h03288833, 1, MEXT,   0, 1, 17, 1, 18, 1, 16, 1);  // Mul.
        add_entry(32'h0FF0000F, 0, CSR,    0, 1,  0, 0,  0, 0,  0, 0);  // Fence.
        add_entry(32'h00000073, 0, CSR,    0, 1,  0, 0,  0, 0,  0, 0);  // Ecall.
        add_entry(32'h00100073, 0, CSR,    0, 1,  0, 0,  0, 0,  0, 0);  // Ebreak.
        add_entry(32'h30200073, 0, CSR,    0, 1,  0, 0,  0, 0,  0, 0);  // Mret.
        add_entry(32'h300312F3, 0, CSR,    0, 1,  6, 1,  0, 0,  5, 1);  // Csrrw.
        add_entry(32'h3001D2F3, 0, CSR,    0, 1,  0, 0,  0, 0,  5, 1);  // Csrrwi.
        add_entry(32'h00004144, 0, LOAD,   1, 1, 10, 1,  0, 0,  9, 1);  // C.lw.
        add_entry(32'h0000C20C, 0, STORE,  1, 1, 12, 1, 11, 1,  0, 0);  // C.sw.
        add_entry(32'h00004402, 0, LOAD,   1, 1,  2, 1,  0, 0,  8, 1);  // C.lwsp.
        add_entry(32'h0000C23E, 0, STORE,  1, 1,  2, 1, 15, 1,  0, 0);  // C.swsp.
        add_entry(32'h00002001, 1, JAL,    1, 1,  0, 0,  0, 0,  1, 1);  // C.jal.
        add_entry(32'h0000C081, 0, BRANCH, 1, 1,  9, 1,  0, 0,  0, 0);  // C.beqz x9.
        add_entry(32'h0000852E, 0, BASE,   1, 1,  0, 1, 11, 1, 10, 1);  // C.mv reads x0 as rs1.
        add_entry(32'h0000952E, 0, BASE,   1, 1, 10, 1, 11, 1, 10, 1);  // C.add.
        add_entry(32'h00000000, 0, BASE,   1, 0,  2, 1,  0, 0,  8, 1);  // Addi4spn with zero imm.
        add_entry(32'h0000070B, 0, BASE,   0, 0,  0, 0,  0, 0,  0, 0);
        add_entry(32'h00008084, 0, BASE,   1, 0,  0, 0,  0, 0,  0, 0);
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            value_errors++;
            $display("Fail at %0d ns: %s expected %0h, got %0h", $time, name, exp, act);
        end
    endtask

    // An index below zero checks valid_o alone.
    task automatic check_result(input logic exp_valid, input int idx);
        check_value("valid_o", exp_valid, valid_o);
        if (idx >= 0) begin
            check_value("itype_o", tbl[idx].itype, itype_o);
            check_value("compressed_o", tbl[idx].comp, compressed_o);
            check_value("known_o", tbl[idx].known, known_o);
            check_value("rs1_o", tbl[idx].rs1, rs1_o);
            check_value("rs1_used_o", tbl[idx].rs1_used, rs1_used_o);
            check_value("rs2_o", tbl[idx].rs2, rs2_o);
            check_value("rs2_used_o", tbl[idx].rs2_used, rs2_used_o);
            check_value("rd_o", tbl[idx].rd, rd_o);
            check_value("rd_used_o", tbl[idx].rd_used, rd_used_o);
        end
    endtask

    // Drives one cycle and checks what the previous cycle put in.
    task automatic apply_cycle(input logic v, input logic [31:0] word,
                               input logic exp_valid, input int exp_idx);
        @(posedge s_clk_i);
        valid_i <= v;
        instr_i <= word;
        @(negedge s_clk_i);
        check_result(exp_valid, exp_idx);
    endtask

    initial begin
        int   i;
        int   wait_cnt;
        logic pend_valid;
        int   pend_idx;

        checks         = 0;
        value_errors   = 0;
        timeout_errors = 0;
        load_table();

        wait_cnt = 0;
        while (rst_i !== 1'b0 && wait_cnt < 40) begin
            @(posedge s_clk_i);
            wait_cnt++;
        end
        if (rst_i !== 1'b0) begin
            timeout_errors++;
            $display("Timeout: reset was not released after %0d cycles", wait_cnt);
        end else begin
            // First cycle after reset sees a cleared result register.
            @(negedge s_clk_i);
            check_value("valid_o", 1'b0, valid_o);
            check_value("compressed_o", 1'b0, compressed_o);
            check_value("known_o", 1'b0, known_o);
            check_value("itype_o", BASE, itype_o);
            check_value("rs1_o", 5'd0, rs1_o);
            check_value("rs1_used_o", 1'b0, rs1_used_o);
            check_value("rs2_o", 5'd0, rs2_o);
            check_value("rs2_used_o", 1'b0, rs2_used_o);
            check_value("rd_o", 5'd0, rd_o);
            check_value("rd_used_o", 1'b0, rd_used_o);
            repeat (4) apply_cycle(1'b0, $random(seed), 1'b0, -1);

            pend_valid = 1'b0;
            pend_idx   = -1;
            for (i = 0; i < tbl.size(); i++) begin
                if (tbl[i].bubble) begin
                    // The result must hold through this idle cycle.
                    apply_cycle(1'b0, $random(seed), pend_valid, pend_idx);
                    pend_valid = 1'b0;
                end
                apply_cycle(1'b1, tbl[i].instr, pend_valid, pend_idx);
                pend_valid = 1'b1;
                pend_idx   = i;
            end
            apply_cycle(1'b0, $random(seed), pend_valid, pend_idx);

            wait_cnt = 0;
            while (valid_o !== 1'b0 && wait_cnt < 8) begin
                @(negedge s_clk_i);
                wait_cnt++;
            end
            if (valid_o !== 1'b0) begin
                timeout_errors++;
                $display("Timeout: valid_o did not drop after the last entry");
            end
        end

        $display("Checks: %0d, value errors: %0d, timeouts: %0d",
                 checks, value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/classifier_pkg.sv
/*
 * Instruction classifier package.
 * Instruction class encoding and the packed decode result types
 * shared by both decoders and the merge stage.
 */
`default_nettype none

package classifier_pkg;

`include "classifier_settings.svh"

    typedef enum logic [3:0] {
        BASE,
        MEXT,
        LOAD,
        STORE,
        BRANCH,
        JAL,
        JALR,
        CSR
    } itype_e;

    typedef struct packed {
        logic [`CLS_RAW-1:0] rs1;
        logic [`CLS_RAW-1:0] rs2;
        logic                rs1_used;
        logic                rs2_used;
    } source_t;

    typedef struct packed {
        logic [`CLS_RAW-1:0] rd;
        logic                rd_used;
    } dest_t;

    // One classified instruction, 23 bits.
    typedef struct packed {
        itype_e  itype;
        source_t src;
        dest_t   dst;
        logic    known;
    } decode_t;

endpackage

`default_nettype wire

//--- hdl/classifier_settings.svh
/*
 * Instruction classifier settings.
 * Word widths, register address width and RISC-V major opcodes.
 */
`ifndef CLASSIFIER_SETTINGS_SVH
`define CLASSIFIER_SETTINGS_SVH

`define CLS_ILEN        32
`define CLS_CLEN        16
`define CLS_RAW         5

// Major opcodes, bits [6:2] of a 32-bit word.
`define CLS_OPC_LOAD    5'b00000
`define CLS_OPC_STORE   5'b01000
`define CLS_OPC_BRANCH  5'b11000
`define CLS_OPC_JAL     5'b11011
`define CLS_OPC_JALR    5'b11001
`define CLS_OPC_OPIMM   5'b00100
`define CLS_OPC_OP      5'b01100
`define CLS_OPC_LUI     5'b01101
`define CLS_OPC_AUIPC   5'b00101
`define CLS_OPC_FENCE   5'b00011
`define CLS_OPC_SYSTEM  5'b11100
`define CLS_OPC_WIDE    2'b11       // Low bits of any 32-bit encoding.

`endif

//--- hdl/decode_if.sv
/*
 * Decoder result interface.
 * Carries one decoder's class, source and destination registers
 * and recognition flag to the merge stage.
 */
`timescale 1ns/1ps
`default_nettype none

interface decode_if import classifier_pkg::*; ();

    itype_e  itype;
    source_t src;
    dest_t   dst;
    logic    known;

    modport dec (
        output itype,
        output src,
        output dst,
        output known
    );

    modport mrg (
        input itype,
        input src,
        input dst,
        input known
    );

endinterface

`default_nettype wire

//--- hdl/decode_merge.sv
/*
 * Decode merge stage.
 * Picks the 32-bit or compressed decoder result by encoding width
 * and holds it in a one-stage output register with its valid.
 */
`timescale 1ns/1ps
`default_nettype none

module decode_merge import classifier_pkg::*; (
    input  logic    s_clk_i,
    input  logic    rst_i,
    input  logic    valid_i,
    input  logic    wide_i,
    decode_if.mrg   full,
    decode_if.mrg   comp,
    output logic    valid_o,
    output logic    compressed_o,
    output decode_t result_o
);

    decode_t full_res;
    decode_t comp_res;
    decode_t sel_res;

    assign full_res = {full.itype, full.src, full.dst, full.known};
    assign comp_res = {comp.itype, comp.src, comp.dst, comp.known};
    assign sel_res  = wide_i ? full_res : comp_res;

    always_ff @(posedge s_clk_i) begin
        if (rst_i) begin
            valid_o      <= 1'b0;
            compressed_o <= 1'b0;
            result_o     <= '0;
        end else begin
            valid_o <= valid_i;
            if (valid_i) begin  // Hold the last result through bubbles.
                compressed_o <= ~wide_i;
                result_o     <= sel_res;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/instr_classifier.sv
/*
 * RISC-V instruction classifier.
 * Runs the 32-bit and compressed decoders side by side and registers
 * the selected result one cycle after the valid strobe.
 */
`timescale 1ns/1ps
`default_nettype none

`include "classifier_settings.svh"

module instr_classifier import classifier_pkg::*; (
    input  logic                s_clk_i,
    input  logic                rst_i,
    input  logic                valid_i,
    input  logic [`CLS_ILEN-1:0] instr_i,
    output logic                valid_o,
    output logic                compressed_o,
    output logic                known_o,
    output itype_e              itype_o,
    output logic [`CLS_RAW-1:0] rs1_o,
    output logic [`CLS_RAW-1:0] rs2_o,
    output logic [`CLS_RAW-1:0] rd_o,
    output logic                rs1_used_o,
    output logic                rs2_used_o,
    output logic                rd_used_o
);

    logic    wide;
    decode_t result;

    decode_if if32 ();
    decode_if if16 ();

    assign wide = (instr_i[1:0] == `CLS_OPC_WIDE);

    rv32_decode u_rv32 (
        .instr_i (instr_i),
        .out     (if32)
    );

    rvc_decode u_rvc (
        .instr_i (instr_i[`CLS_CLEN-1:0]),
        .out     (if16)
    );

    decode_merge u_merge (
        .s_clk_i      (s_clk_i),
        .rst_i        (rst_i),
        .valid_i      (valid_i),
        .wide_i       (wide),
        .full         (if32),
        .comp         (if16),
        .valid_o      (valid_o),
        .compressed_o (compressed_o),
        .result_o     (result)
    );

    assign itype_o    = result.itype;
    assign known_o    = result.known;
    assign rs1_o      = result.src.rs1;
    assign rs2_o      = result.src.rs2;
    assign rs1_used_o = result.src.rs1_used;
    assign rs2_used_o = result.src.rs2_used;
    assign rd_o       = result.dst.rd;
    assign rd_used_o  = result.dst.rd_used;

endmodule

`default_nettype wire

//--- hdl/rv32_decode.sv
/*
 * RV32 decoder.
 * Classifies a 32-bit encoding by major opcode and function fields,
 * reporting used source registers and the written destination.
 * Purely combinational.
 */
`timescale 1ns/1ps
`default_nettype none

`include "classifier_settings.svh"

module rv32_decode import classifier_pkg::*; (
    input  logic [`CLS_ILEN-1:0] instr_i,
    decode_if.dec                out
);

    logic [4:0]          opcode;
    logic [2:0]          funct3;
    logic [11:0]         imm12;
    logic [`CLS_RAW-1:0] rd;
    logic [`CLS_RAW-1:0] rs1;
    logic [`CLS_RAW-1:0] rs2;

    itype_e  itype;
    source_t src;
    dest_t   dst;
    logic    known;

    assign opcode = instr_i[6:2];
    assign funct3 = instr_i[14:12];
    assign imm12  = instr_i[31:20];
    assign rd     = instr_i[11:7];
    assign rs1    = instr_i[19:15];
    assign rs2    = instr_i[24:20];

    always_comb begin
        itype = BASE;
        src   = '0;
        dst   = '0;
        known = 1'b1;
        case (opcode)
            `CLS_OPC_LUI, `CLS_OPC_AUIPC: begin
                dst.rd      = rd;
                dst.rd_used = 1'b1;
            end
            `CLS_OPC_JAL: begin
                itype       = JAL;
                dst.rd      = rd;
                dst.rd_used = 1'b1;
            end
            `CLS_OPC_JALR: begin
                itype        = JALR;
                src.rs1      = rs1;
                src.rs1_used = 1'b1;
                dst.rd       = rd;
                dst.rd_used  = 1'b1;
                known        = (funct3 == 3'b000);
            end
            `CLS_OPC_BRANCH: begin
                itype        = BRANCH;
                src.rs1      = rs1;
                src.rs2      = rs2;
                src.rs1_used = 1'b1;
                src.rs2_used = 1'b1;
                known        = (funct3[2:1] != 2'b01);  // Funct3 2 and 3 are reserved.
            end
            `CLS_OPC_LOAD: begin
                itype        = LOAD;
                src.rs1      = rs1;
                src.rs1_used = 1'b1;
                dst.rd       = rd;
                dst.rd_used  = 1'b1;
                known        = funct3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
            end
            `CLS_OPC_STORE: begin
                itype        = STORE;
                src.rs1      = rs1;
                src.rs2      = rs2;
                src.rs1_used = 1'b1;
                src.rs2_used = 1'b1;
                known        = (funct3 < 3'd3);  // Sb, sh, sw.
            end
            `CLS_OPC_OPIMM: begin
                src.rs1      = rs1;
                src.rs1_used = 1'b1;
                dst.rd       = rd;
                dst.rd_used  = 1'b1;
            end
            `CLS_OPC_OP: begin
                itype        = instr_i[25] ? MEXT : BASE;  // Funct7 bit 0 selects mul/div.
                src.rs1      = rs1;
                src.rs2      = rs2;
                src.rs1_used = 1'b1;
                src.rs2_used = 1'b1;
                dst.rd       = rd;
                dst.rd_used  = 1'b1;
            end
            `CLS_OPC_FENCE: begin
                itype = CSR;
                known = (funct3[2:1] == 2'b00);  // Fence and fence.i.
            end
            `CLS_OPC_SYSTEM: begin
                itype = CSR;
                if (rd == '0 && rs1 == '0) begin
                    // Ecall, ebreak and mret.
                    known = (funct3 == 3'b000) &&
                            (imm12 inside {12'h000, 12'h001, 12'h302});
                end else begin
                    dst.rd       = rd;
                    dst.rd_used  = 1'b1;
                    src.rs1      = funct3[2] ? '0 : rs1;  // Immediate forms use no rs1.
                    src.rs1_used = ~funct3[2];
                    known        = (funct3[1:0] != 2'b00);
                end
            end
            default: begin
                known = 1'b0;
            end
        endcase
    end

    assign out.itype = itype;
    assign out.src   = src;
    assign out.dst   = dst;
    assign out.known = known;

endmodule

`default_nettype wire

//--- hdl/rvc_decode.sv
/*
 * RVC decoder.
 * Classifies a 16-bit compressed encoding by quadrant and funct3.
 * The 3-bit register fields map onto x8 to x15.
 */
`timescale 1ns/1ps
`default_nettype none

`include "classifier_settings.svh"

module rvc_decode import classifier_pkg::*; (
    input  logic [`CLS_CLEN-1:0] instr_i,
    decode_if.dec                out
);

    logic [1:0]          quad;
    logic [2:0]          funct3;
    logic [`CLS_RAW-1:0] r_hi;       // Full field [11:7].
    logic [`CLS_RAW-1:0] r_lo;       // Full field [6:2].
    logic [`CLS_RAW-1:0] rp_hi;      // Expanded field [9:7].
    logic [`CLS_RAW-1:0] rp_lo;      // Expanded field [4:2].
    logic                imm6_nz;

    itype_e  itype;
    source_t src;
    dest_t   dst;
    logic    known;

    assign quad    = instr_i[1:0];
    assign funct3  = instr_i[15:13];
    assign r_hi    = instr_i[11:7];
    assign r_lo    = instr_i[6:2];
    assign rp_hi   = {2'b01, instr_i[9:7]};
    assign rp_lo   = {2'b01, instr_i[4:2]};
    assign imm6_nz = |{instr_i[12], instr_i[6:2]};

    always_comb begin
        itype = BASE;
        src   = '0;
        dst   = '0;
        known = 1'b1;
        case ({quad, funct3})
            5'b00_000: begin  // Addi4spn.
                src   = '{rs1: 5'd2, rs2: '0, rs1_used: 1'b1, rs2_used: 1'b0};
                dst   = '{rd: rp_lo, rd_used: 1'b1};
                known = |instr_i[12:5];
            end
            5'b00_010: begin
                itype = LOAD;
                src   = '{rs1: rp_hi, rs2: '0, rs1_used: 1'b1, rs2_used: 1'b0};
                dst   = '{rd: rp_lo, rd_used: 1'b1};
            end
            5'b00_110: begin
                itype = STORE;
                src   = '{rs1: rp_hi, rs2: rp_lo, rs1_used: 1'b1, rs2_used: 1'b1};
            end
            5'b01_000: begin
                if (r_hi != '0) begin  // Otherwise c.nop.
                    src = '{rs1: r_hi, rs2: '0, rs1_used: 1'b1, rs2_used: 1'b0};
                    dst = '{rd: r_hi, rd_used: 1'b1};
                end
            end
            5'b01_001: begin
                itype = JAL;
                dst   = '{rd: 5'd1, rd_used: 1'b1};
            end
            5'b01_010: begin  // C.li.
                dst = '{rd: r_hi, rd_used: 1'b1};
            end
            5'b01_011: begin
                known = imm6_nz;
                if (imm6_nz && r_hi == 5'd2) begin  // C.addi16sp.
                    src = '{rs1: 5'd2, rs2: '0, rs1_used: 1'b1, rs2_used: 1'b0};
                    dst = '{rd: 5'd2, rd_used: 1'b1};
                end else if (imm6_nz) begin
                    dst = '{rd: r_hi, rd_used: 1'b1};
                end
            end
            5'b01_100: begin
                dst = '{rd: rp_hi, rd_used: 1'b1};
                if (instr_i[11:10] == 2'b11) begin  // Sub, xor, or, and.
                    src   = '{rs1: rp_hi, rs2: rp_lo, rs1_used: 1'b1, rs2_used: 1'b1};
                    known = ~instr_i[12];
                end else begin
                    src = '{rs1: rp_hi, rs2: '0, rs1_used: 1'b1, rs2_used: 1'b0};
                end
            end
            5'b01_101: begin  // C.j.
                itype = JAL;
            end
            5'b01_110, 5'b01_111: begin
                itype = BRANCH;
                src   = '{rs1: rp_hi, rs2: '0, rs1_used: 1'b1, rs2_used: 1'b0};
            end
            5'b10_000: begin
                src   = '{rs1: r_hi, rs2: '0, rs1_used: 1'b1, rs2_used: 1'b0};
                dst   = '{rd: r_hi, rd_used: 1'b1};
                known = ~instr_i[12];
            end
            5'b10_010: begin
                itype = LOAD;
                src   = '{rs1: 5'd2, rs2: '0, rs1_used: 1'b1, rs2_used: 1'b0};
                dst   = '{rd: r_hi, rd_used: 1'b1};
                known = (r_hi != '0);
            end
            5'b10_100: begin
                if (r_lo != '0) begin
                    // C.mv is add rd, x0, rs2.
                    src.rs1      = instr_i[12] ? r_hi : '0;
                    src.rs2      = r_lo;
                    src.rs1_used = 1'b1;
                    src.rs2_used = 1'b1;
                    dst          = '{rd: r_hi, rd_used: 1'b1};
                end else if (r_hi != '0) begin
                    itype = JALR;
                    src   = '{rs1: r_hi, rs2: '0, rs1_used: 1'b1, rs2_used: 1'b0};
                    dst   = instr_i[12] ? '{rd: 5'd1, rd_used: 1'b1} : '0;
                end else begin
                    itype = CSR;                // C.ebreak.
                    known = instr_i[12];
                end
            end
            5'b10_110: begin
                itype = STORE;
                src   = '{rs1: 5'd2, rs2: r_lo, rs1_used: 1'b1, rs2_used: 1'b1};
            end
            default: begin
                known = 1'b0;
            end
        endcase
    end

    assign out.itype = itype;
    assign out.src   = src;
    assign out.dst   = dst;
    assign out.known = known;

endmodule

`default_nettype wire
